// File: src/vcu_cfg.svh
/*
 * vector control unit configuration
 * instruction width, register index width and the bit positions
 * of the vector instruction fields
 */

`ifndef VCU_CFG_SVH
`define VCU_CFG_SVH

// instruction and register index widths
`define VCU_ILEN       32
`define VCU_REG_W      5

// field widths
`define VCU_OPCODE_W   7
`define VCU_FUNCT3_W   3
`define VCU_ZIMM11_W   11

// field positions, lsb of each field
`define VCU_VD_LSB     7
`define VCU_FUNCT3_LSB 12
`define VCU_VS1_LSB    15
`define VCU_VS2_LSB    20
`define VCU_FUNCT6_LSB 26

// mask bit
`define VCU_VM_BIT     25

`endif

// File: src/vcu_pkg.sv
/*
 * vector control unit types
 * opcodes, funct3/funct6 codes, decoded ops, unit selects and the
 * packed structs shared by the decode blocks
 */

package vcu_pkg;

  typedef enum logic [6:0] {
    OPC_OTHER = 7'b0000000,
    LOAD_FP   = 7'b0000111,
    STORE_FP  = 7'b0100111,
    VECTOR    = 7'b1010111
  } opcode_t;

  typedef enum logic [2:0] {
    OPIVV = 3'd0,
    OPMVV = 3'd2,
    OPIVI = 3'd3,
    OPIVX = 3'd4,
    OPMVX = 3'd6,
    OPCFG = 3'd7
  } vfunct3_t;

  // opi and opm codes share one space, funct3 picks the group
  typedef enum logic [5:0] {
    VADD    = 6'b000000,
    VSUB    = 6'b000010,
    VRSUB   = 6'b000011,
    VMINU   = 6'b000100,
    VMIN    = 6'b000101,
    VMAXU   = 6'b000110,
    VMAX    = 6'b000111,
    VAND    = 6'b001001,
    VOR     = 6'b001010,
    VXOR    = 6'b001011,
    VMSEQ   = 6'b011000,
    VMSNE   = 6'b011001,
    VMSLTU  = 6'b011010,
    VMSLT   = 6'b011011,
    VMSLEU  = 6'b011100,
    VMSLE   = 6'b011101,
    VMSGTU  = 6'b011110,
    VMSGT   = 6'b011111,
    VDIVU   = 6'b100000,
    VDIV    = 6'b100001,
    VREMU   = 6'b100010,
    VREM    = 6'b100011,
    VMULHU  = 6'b100100,
    VSLL    = 6'b100101,
    VMULHSU = 6'b100110,
    VMULH   = 6'b100111,
    VSRL    = 6'b101000,
    VSRA    = 6'b101001
  } vfunct6_t;

  // vmul is the opm reading of the vsll code
  localparam vfunct6_t VMUL = VSLL;

  typedef enum logic [5:0] {
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VAND, OP_VOR, OP_VXOR,
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIV, OP_VDIVU, OP_VREM, OP_VREMU,
    OP_BAD = 6'h3f
  } vop_t;

  typedef enum logic [2:0] {
    FU_ARITH, FU_MUL, FU_DIV, FU_LOAD, FU_STORE, FU_NONE
  } fu_type_t;

  typedef enum logic [2:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR,
    VALU_XOR, VALU_COMP, VALU_MM, VALU_SHIFT
  } valu_op_t;

  typedef enum logic [2:0] {
    VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT
  } comp_type_t;

  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_t;

  typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shift_type_t;

  typedef enum logic [1:0] {SRC_V, SRC_X, SRC_I} src_type_t;

  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfg_sel_t;

  typedef enum logic [2:0] {
    WIDTH8  = 3'd0,
    WIDTH16 = 3'd5,
    WIDTH32 = 3'd6
  } mem_width_t;

  typedef struct packed {
    vfunct6_t   funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    vfunct3_t   funct3;
    logic [4:0] vd;
    opcode_t    opcode;
  } vinstr_fields_t;

  typedef struct packed {
    vop_t op;
    logic is_vopi;
    logic is_vopm;
    logic illegal;
  } vop_info_t;

  typedef struct packed {
    fu_type_t    fu_type;
    valu_op_t    aluop;
    comp_type_t  comp_type;
    minmax_t     minmax_type;
    shift_type_t shift_type;
    logic        is_signed;
    logic        mul_high;
    logic [1:0]  mul_signed;
    logic        div_quot;
    logic        div_signed;
    cfg_sel_t    cfgsel;
    logic        is_load;
    logic        is_store;
    src_type_t   rs1_type;
    src_type_t   rs2_type;
    logic [4:0]  imm_5;
    logic        sign_extend;
    logic [1:0]  wen;
    logic        de_en;
    logic        illegal;
  } vcu_ctrl_t;

  // element width carried in funct3 of a vector load/store
  function automatic logic mem_width_ok(logic [2:0] f3);
    mem_width_t w;
    w = mem_width_t'(f3);
    return (w == WIDTH8) || (w == WIDTH16) || (w == WIDTH32);
  endfunction

endpackage

// File: src/vop_decoder.sv
/*
 * vector op decoder
 * classifies an instruction as opi or opm and maps funct6/funct3
 * to the decoded op, flagging pairings outside the kept subset
 */

`timescale 1ns/1ps

module vop_decoder import vcu_pkg::*; (
  input  vinstr_fields_t fields,
  output vop_info_t      info
);

  logic is_vopi;
  logic is_vopm;
  logic no_vv;
  logic no_vi;
  vop_t op;

  assign is_vopi = (fields.opcode == VECTOR) &&
                   ((fields.funct3 == OPIVV) || (fields.funct3 == OPIVX) ||
                    (fields.funct3 == OPIVI));
  assign is_vopm = (fields.opcode == VECTOR) &&
                   ((fields.funct3 == OPMVV) || (fields.funct3 == OPMVX));

  // category restrictions inside the opi group
  assign no_vv = (fields.funct3 != OPIVV);
  assign no_vi = (fields.funct3 != OPIVI);

  always_comb begin
    op = OP_BAD;
    if (is_vopi) begin
      case (fields.funct6)
        VADD:    op = OP_VADD;
        VSUB:    op = no_vi ? OP_VSUB : OP_BAD;
        VRSUB:   op = no_vv ? OP_VRSUB : OP_BAD;
        VMINU:   op = no_vi ? OP_VMINU : OP_BAD;
        VMIN:    op = no_vi ? OP_VMIN : OP_BAD;
        VMAXU:   op = no_vi ? OP_VMAXU : OP_BAD;
        VMAX:    op = no_vi ? OP_VMAX : OP_BAD;
        VAND:    op = OP_VAND;
        VOR:     op = OP_VOR;
        VXOR:    op = OP_VXOR;
        VMSEQ:   op = OP_VMSEQ;
        VMSNE:   op = OP_VMSNE;
        // less-than has no immediate form
        VMSLTU:  op = no_vi ? OP_VMSLTU : OP_BAD;
        VMSLT:   op = no_vi ? OP_VMSLT : OP_BAD;
        VMSLEU:  op = OP_VMSLEU;
        VMSLE:   op = OP_VMSLE;
        // greater-than has no vector-vector form
        VMSGTU:  op = no_vv ? OP_VMSGTU : OP_BAD;
        VMSGT:   op = no_vv ? OP_VMSGT : OP_BAD;
        VSLL:    op = OP_VSLL;
        VSRL:    op = OP_VSRL;
        VSRA:    op = OP_VSRA;
        default: op = OP_BAD;
      endcase
    end else if (is_vopm) begin
      // mul and div take both opmvv and opmvx
      case (fields.funct6)
        VMUL:    op = OP_VMUL;
        VMULH:   op = OP_VMULH;
        VMULHU:  op = OP_VMULHU;
        VMULHSU: op = OP_VMULHSU;
        VDIV:    op = OP_VDIV;
        VDIVU:   op = OP_VDIVU;
        VREM:    op = OP_VREM;
        VREMU:   op = OP_VREMU;
        default: op = OP_BAD;
      endcase
    end
  end

  // config, memory and foreign opcodes all land on OP_BAD here
  assign info.op      = op;
  assign info.is_vopi = is_vopi;
  assign info.is_vopm = is_vopm;
  assign info.illegal = (op == OP_BAD);

endmodule

// File: src/vfu_select.sv
/*
 * functional unit select
 * picks the execution unit for a decoded op and derives the alu,
 * compare, min/max, shift, multiply and divide sub-controls
 */

`timescale 1ns/1ps

module vfu_select import vcu_pkg::*; (
  input  vinstr_fields_t fields,
  input  vop_info_t      info,
  output fu_type_t       fu_type,
  output valu_op_t       aluop,
  output comp_type_t     comp_type,
  output minmax_t        minmax_type,
  output shift_type_t    shift_type,
  output logic           is_signed,
  output logic           mul_high,
  output logic [1:0]     mul_signed,
  output logic           div_quot,
  output logic           div_signed
);

  logic load_ok;
  logic store_ok;

  assign load_ok  = (fields.opcode == LOAD_FP) && mem_width_ok(fields.funct3);
  assign store_ok = (fields.opcode == STORE_FP) && mem_width_ok(fields.funct3);

  always_comb begin
    case (info.op)
      OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU: fu_type = FU_MUL;
      OP_VDIV, OP_VDIVU, OP_VREM, OP_VREMU:     fu_type = FU_DIV;
      OP_BAD: begin
        if (load_ok) begin
          fu_type = FU_LOAD;
        end else if (store_ok) begin
          fu_type = FU_STORE;
        end else begin
          fu_type = FU_NONE;
        end
      end
      default: fu_type = FU_ARITH;
    endcase
  end

  always_comb begin
    case (info.op)
      OP_VSUB, OP_VRSUB: aluop = VALU_SUB;
      OP_VAND:           aluop = VALU_AND;
      OP_VOR:            aluop = VALU_OR;
      OP_VXOR:           aluop = VALU_XOR;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: aluop = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:     aluop = VALU_MM;
      OP_VSLL, OP_VSRL, OP_VSRA:                aluop = VALU_SHIFT;
      default:           aluop = VALU_ADD;
    endcase
  end

  always_comb begin
    case (info.op)
      OP_VMSNE:  comp_type = VSNE;
      OP_VMSLTU: comp_type = VSLTU;
      OP_VMSLT:  comp_type = VSLT;
      OP_VMSLEU: comp_type = VSLEU;
      OP_VMSLE:  comp_type = VSLE;
      OP_VMSGTU: comp_type = VSGTU;
      OP_VMSGT:  comp_type = VSGT;
      default:   comp_type = VSEQ;
    endcase
  end

  always_comb begin
    case (info.op)
      OP_VMINU: minmax_type = MINU;
      OP_VMAX:  minmax_type = MAX;
      OP_VMAXU: minmax_type = MAXU;
      default:  minmax_type = MIN;
    endcase
  end

  always_comb begin
    case (info.op)
      OP_VSRL: shift_type = SH_SRL;
      OP_VSRA: shift_type = SH_SRA;
      default: shift_type = SH_SLL;
    endcase
  end

  always_comb begin
    case (info.op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX,
      OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VSRA,
      OP_VMUL, OP_VMULH, OP_VMULHSU, OP_VDIV, OP_VREM: is_signed = 1'b1;
      default: is_signed = 1'b0;
    endcase
  end

  // multiplier: {rs2 signed, rs1 signed}
  assign mul_high = (info.op == OP_VMULH) || (info.op == OP_VMULHU) ||
                    (info.op == OP_VMULHSU);
  assign mul_signed = ((info.op == OP_VMUL) || (info.op == OP_VMULH)) ? 2'b11 :
                      (info.op == OP_VMULHSU) ? 2'b10 : 2'b00;

  // divider: quotient versus remainder
  assign div_quot   = (info.op == OP_VDIV) || (info.op == OP_VDIVU);
  assign div_signed = (info.op == OP_VDIV) || (info.op == OP_VREM);

endmodule

// File: src/voperand_ctrl.sv
/*
 * operand and register controls
 * config select, load/store detection, operand source types,
 * immediate handling, write enable and unit dispatch enable
 */

`timescale 1ns/1ps

module voperand_ctrl import vcu_pkg::*; (
  input  vinstr_fields_t fields,
  input  vop_info_t      info,
  output cfg_sel_t       cfgsel,
  output logic           is_load,
  output logic           is_store,
  output src_type_t      rs1_type,
  output src_type_t      rs2_type,
  output logic [4:0]     imm_5,
  output logic           sign_extend,
  output logic [1:0]     wen,
  output logic           de_en
);

  localparam logic [1:0] MOP_STRIDED = 2'b10;

  logic is_cfg;
  logic vec_ok;
  logic mem_op;

  assign is_cfg = (fields.opcode == VECTOR) && (fields.funct3 == OPCFG);

  // funct6[5:4] holds instr[31:30]
  always_comb begin
    cfgsel = NOT_CFG;
    if (is_cfg) begin
      if (!fields.funct6[5]) begin
        cfgsel = VSETVLI;
      end else if (fields.funct6[4]) begin
        cfgsel = VSETIVLI;
      end else begin
        cfgsel = VSETVL;
      end
    end
  end

  assign is_load  = (fields.opcode == LOAD_FP) && mem_width_ok(fields.funct3);
  assign is_store = (fields.opcode == STORE_FP) && mem_width_ok(fields.funct3);
  assign mem_op   = is_load || is_store;

  // a legal opi/opm op, never a config op
  assign vec_ok = (info.is_vopi || info.is_vopm) && !info.illegal;

  // scalar rs1 for memory base, .vx forms, vsetvli and vsetvl
  always_comb begin
    if (mem_op || (cfgsel == VSETVLI) || (cfgsel == VSETVL) ||
        ((fields.opcode == VECTOR) &&
         ((fields.funct3 == OPIVX) || (fields.funct3 == OPMVX)))) begin
      rs1_type = SRC_X;
    end else if (((fields.opcode == VECTOR) && (fields.funct3 == OPIVI)) ||
                 (cfgsel == VSETIVLI)) begin
      rs1_type = SRC_I;
    end else begin
      rs1_type = SRC_V;
    end
  end

  // mop lives in instr[27:26]; strided access takes the stride from rs2
  assign rs2_type = (mem_op && (fields.funct6[1:0] == MOP_STRIDED)) ? SRC_X : SRC_V;

  assign imm_5 = fields.vs1;

  // shift amounts and the vsetivli avl are unsigned
  assign sign_extend = !((info.op == OP_VSLL) || (info.op == OP_VSRL) ||
                         (info.op == OP_VSRA) || (cfgsel == VSETIVLI));

  assign wen   = (is_load || vec_ok) ? 2'b11 : 2'b00;
  assign de_en = vec_ok;

endmodule

// File: src/vector_control_unit.sv
/*
 * vector control unit
 * splits the instruction into fields, runs the three decoders
 * and registers the packed control word one cycle later
 */

`timescale 1ns/1ps

`include "vcu_cfg.svh"

module vector_control_unit import vcu_pkg::*; (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic [`VCU_ILEN-1:0]     instr,
  input  logic                     instr_valid,
  output vcu_ctrl_t                ctrl,
  output logic                     ctrl_valid,
  output logic [`VCU_ZIMM11_W-1:0] zimm_11
);

  vinstr_fields_t fields;
  vop_info_t      info;
  vcu_ctrl_t      ctrl_d;
  logic [1:0]     wen_raw;
  logic           de_en_raw;

  assign fields.funct6 = vfunct6_t'(instr[`VCU_ILEN-1:`VCU_FUNCT6_LSB]);
  assign fields.vm     = instr[`VCU_VM_BIT];
  assign fields.vs2    = instr[`VCU_VS2_LSB +: `VCU_REG_W];
  assign fields.vs1    = instr[`VCU_VS1_LSB +: `VCU_REG_W];
  assign fields.funct3 = vfunct3_t'(instr[`VCU_FUNCT3_LSB +: `VCU_FUNCT3_W]);
  assign fields.vd     = instr[`VCU_VD_LSB +: `VCU_REG_W];
  assign fields.opcode = opcode_t'(instr[`VCU_OPCODE_W-1:0]);

  vop_decoder u_vop_decoder (
    .fields (fields),
    .info   (info)
  );

  vfu_select u_vfu_select (
    .fields      (fields),
    .info        (info),
    .fu_type     (ctrl_d.fu_type),
    .aluop       (ctrl_d.aluop),
    .comp_type   (ctrl_d.comp_type),
    .minmax_type (ctrl_d.minmax_type),
    .shift_type  (ctrl_d.shift_type),
    .is_signed   (ctrl_d.is_signed),
    .mul_high    (ctrl_d.mul_high),
    .mul_signed  (ctrl_d.mul_signed),
    .div_quot    (ctrl_d.div_quot),
    .div_signed  (ctrl_d.div_signed)
  );

  voperand_ctrl u_voperand_ctrl (
    .fields      (fields),
    .info        (info),
    .cfgsel      (ctrl_d.cfgsel),
    .is_load     (ctrl_d.is_load),
    .is_store    (ctrl_d.is_store),
    .rs1_type    (ctrl_d.rs1_type),
    .rs2_type    (ctrl_d.rs2_type),
    .imm_5       (ctrl_d.imm_5),
    .sign_extend (ctrl_d.sign_extend),
    .wen         (wen_raw),
    .de_en       (de_en_raw)
  );

  // no register write or dispatch from an empty slot
  assign ctrl_d.wen   = instr_valid ? wen_raw : 2'b00;
  assign ctrl_d.de_en = instr_valid && de_en_raw;

  // memory and config ops are legal even though the op decoder rejects them
  assign ctrl_d.illegal = info.illegal && !ctrl_d.is_load && !ctrl_d.is_store &&
                          (ctrl_d.cfgsel == NOT_CFG);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ctrl         <= '0;
      ctrl.fu_type <= FU_NONE;
      ctrl_valid   <= 1'b0;
    end else begin
      ctrl       <= ctrl_d;
      ctrl_valid <= instr_valid;
    end
  end

  // zimm[10:0] of vsetvli, instr[30:20]
  always_ff @(posedge CLK) begin
    zimm_11 <= instr[`VCU_VS2_LSB +: `VCU_ZIMM11_W];
  end

endmodule

// File: bench/vcu_checker.sv
/*
 * vector control unit checker
 * protocol and safety properties on the registered control word
 */

`timescale 1ns/1ps

module vcu_checker import vcu_pkg::*; (
  input logic      CLK,
  input logic      arst_n,
  input logic      instr_valid,
  input vcu_ctrl_t ctrl,
  input logic      ctrl_valid
);

  int unsigned fails = 0;

  // one cycle of latency, no drops, no extras
  valid_follows_input: assert property (
    @(posedge CLK) disable iff (!arst_n) ctrl_valid == $past(instr_valid)
  ) else begin
    fails++;
    $error("ctrl_valid does not follow instr_valid of the previous cycle");
  end

  // an illegal instruction never writes or dispatches
  illegal_is_quiet: assert property (
    @(posedge CLK) disable iff (!arst_n) ctrl.illegal |-> (!ctrl.de_en && ctrl.wen == 2'b00)
  ) else begin
    fails++;
    $error("illegal instruction with de_en or wen set");
  end

  no_valid_in_reset: assert property (
    @(posedge CLK) !arst_n |-> !ctrl_valid
  ) else begin
    fails++;
    $error("ctrl_valid high while in reset");
  end

endmodule

// File: bench/vcu_vectors.svh
/*
 * vector control unit stimulus table
 * one row per instruction slot, driven back to back
 */

`include "vcu_cfg.svh"

// columns: valid, opcode, funct3, funct6 (nf/mew/mop for memory ops),
// then expected fu_type, aluop, sub-control, illegal, de_en, wen,
// rs1_type, is_signed, sign_extend, cfgsel
// sub-control is comp/minmax/shift type, {mul_high, mul_signed}
// or {div_quot, div_signed} depending on the unit
typedef struct packed {
  logic       valid;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic [2:0] fu;
  logic [2:0] aluop;
  logic [2:0] sub;
  logic       illegal;
  logic       de_en;
  logic [1:0] wen;
  logic [1:0] rs1;
  logic       sgn;
  logic       sext;
  logic [1:0] cfg;
} vec_row_t;

localparam int NUM_ROWS = 41;

localparam vec_row_t VECTORS [NUM_ROWS] = '{
  // empty slot right after reset
  '{'0, VECTOR, OPIVV, VADD, FU_ARITH, VALU_ADD, '0, '0, '0, '0, SRC_V, '1, '1, NOT_CFG},
  // legal opi ops
  '{'1, VECTOR, OPIVV, VADD, FU_ARITH, VALU_ADD, '0, '0, '1, '1, SRC_V, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVX, VADD, FU_ARITH, VALU_ADD, '0, '0, '1, '1, SRC_X, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVI, VADD, FU_ARITH, VALU_ADD, '0, '0, '1, '1, SRC_I, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVX, VSUB, FU_ARITH, VALU_SUB, '0, '0, '1, '1, SRC_X, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVI, VRSUB, FU_ARITH, VALU_SUB, '0, '0, '1, '1, SRC_I, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVV, VAND, FU_ARITH, VALU_AND, '0, '0, '1, '1, SRC_V, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVX, VXOR, FU_ARITH, VALU_XOR, '0, '0, '1, '1, SRC_X, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVI, VMSEQ, FU_ARITH, VALU_COMP, VSEQ, '0, '1, '1, SRC_I, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVV, VMSLTU, FU_ARITH, VALU_COMP, VSLTU, '0, '1, '1, SRC_V, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVX, VMSLT, FU_ARITH, VALU_COMP, VSLT, '0, '1, '1, SRC_X, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVI, VMSLE, FU_ARITH, VALU_COMP, VSLE, '0, '1, '1, SRC_I, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVX, VMSGTU, FU_ARITH, VALU_COMP, VSGTU, '0, '1, '1, SRC_X, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVI, VMSGT, FU_ARITH, VALU_COMP, VSGT, '0, '1, '1, SRC_I, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVV, VMINU, FU_ARITH, VALU_MM, MINU, '0, '1, '1, SRC_V, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVX, VMAX, FU_ARITH, VALU_MM, MAX, '0, '1, '1, SRC_X, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPIVI, VSLL, FU_ARITH, VALU_SHIFT, SH_SLL, '0, '1, '1, SRC_I, '0, '0, NOT_CFG},
  '{'1, VECTOR, OPIVV, VSRL, FU_ARITH, VALU_SHIFT, SH_SRL, '0, '1, '1, SRC_V, '0, '0, NOT_CFG},
  '{'1, VECTOR, OPIVX, VSRA, FU_ARITH, VALU_SHIFT, SH_SRA, '0, '1, '1, SRC_X, '1, '0, NOT_CFG},
  // illegal pairings: vsub.vi, vrsub.vv, vmulh in opi, unknown, opm code as opivv
  '{'1, VECTOR, OPIVI, VSUB, FU_NONE, '0, '0, '1, '0, '0, SRC_I, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVV, VRSUB, FU_NONE, '0, '0, '1, '0, '0, SRC_V, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVI, VMULH, FU_NONE, '0, '0, '1, '0, '0, SRC_I, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVV, 6'b010111, FU_NONE, '0, '0, '1, '0, '0, SRC_V, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPIVV, VDIV, FU_NONE, '0, '0, '1, '0, '0, SRC_V, '0, '1, NOT_CFG},
  // gap holding a legal op, must not dispatch
  '{'0, VECTOR, OPMVV, VMUL, FU_MUL, '0, 3'b011, '0, '0, '0, SRC_V, '1, '1, NOT_CFG},
  // opm multiply and divide
  '{'1, VECTOR, OPMVV, VMUL, FU_MUL, '0, 3'b011, '0, '1, '1, SRC_V, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPMVX, VMULH, FU_MUL, '0, 3'b111, '0, '1, '1, SRC_X, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPMVV, VMULHSU, FU_MUL, '0, 3'b110, '0, '1, '1, SRC_V, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPMVX, VMULHU, FU_MUL, '0, 3'b100, '0, '1, '1, SRC_X, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPMVV, VDIV, FU_DIV, '0, 3'b011, '0, '1, '1, SRC_V, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPMVX, VDIVU, FU_DIV, '0, 3'b010, '0, '1, '1, SRC_X, '0, '1, NOT_CFG},
  '{'1, VECTOR, OPMVV, VREM, FU_DIV, '0, 3'b001, '0, '1, '1, SRC_V, '1, '1, NOT_CFG},
  '{'1, VECTOR, OPMVX, VREMU, FU_DIV, '0, 3'b000, '0, '1, '1, SRC_X, '0, '1, NOT_CFG},
  // vsetvli, vsetivli, vsetvl
  '{'1, VECTOR, OPCFG, 6'b000000, FU_NONE, '0, '0, '0, '0, '0, SRC_X, '0, '1, VSETVLI},
  '{'1, VECTOR, OPCFG, 6'b110000, FU_NONE, '0, '0, '0, '0, '0, SRC_I, '0, '0, VSETIVLI},
  '{'1, VECTOR, OPCFG, 6'b100000, FU_NONE, '0, '0, '0, '0, '0, SRC_X, '0, '1, VSETVL},
  // loads, strided load, strided store, store with a bad width
  '{'1, LOAD_FP, WIDTH8, 6'b000000, FU_LOAD, '0, '0, '0, '0, '1, SRC_X, '0, '1, NOT_CFG},
  '{'1, LOAD_FP, WIDTH16, 6'b000010, FU_LOAD, '0, '0, '0, '0, '1, SRC_X, '0, '1, NOT_CFG},
  '{'1, LOAD_FP, WIDTH32, 6'b000000, FU_LOAD, '0, '0, '0, '0, '1, SRC_X, '0, '1, NOT_CFG},
  '{'1, STORE_FP, WIDTH32, 6'b000010, FU_STORE, '0, '0, '0, '0, '0, SRC_X, '0, '1, NOT_CFG},
  '{'1, STORE_FP, 3'd1, 6'b000000, FU_NONE, '0, '0, '1, '0, '0, SRC_V, '0, '1, NOT_CFG}
};

// File: bench/vcu_tb.sv
/*
 * vector control unit testbench
 * drives the table rows back to back and checks each control word
 * one cycle later, with a watchdog and a closing report
 */

`timescale 1ns/1ps

`include "vcu_cfg.svh"

module vcu_tb import vcu_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam logic [31:0] SEED = 32'h6c6a2905;

  logic                     CLK;
  logic                     arst_n;
  logic [`VCU_ILEN-1:0]     instr;
  logic                     instr_valid;
  vcu_ctrl_t                ctrl;
  logic                     ctrl_valid;
  logic [`VCU_ZIMM11_W-1:0] zimm_11;

  `include "vcu_vectors.svh"

  localparam int TIMEOUT_NS = (NUM_ROWS + 20) * CLK_PERIOD;

  logic [`VCU_ILEN-1:0] sent [NUM_ROWS];
  int checks = 0;
  int errors = 0;

  vector_control_unit UUT (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .ctrl        (ctrl),
    .ctrl_valid  (ctrl_valid),
    .zimm_11     (zimm_11)
  );

  bind vector_control_unit vcu_checker u_checker (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .ctrl        (ctrl),
    .ctrl_valid  (ctrl_valid)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  // register fields are random and the rest comes from the row
  function automatic logic [`VCU_ILEN-1:0] build_instr(input vec_row_t r);
    logic [`VCU_ILEN-1:0] w;
    logic [31:0]          rnd;
    rnd = $urandom;
    w = '0;
    w[`VCU_FUNCT6_LSB +: 6] = r.funct6;
    w[`VCU_VM_BIT] = rnd[15];
    w[`VCU_VS2_LSB +: `VCU_REG_W] = rnd[4:0];
    w[`VCU_VS1_LSB +: `VCU_REG_W] = rnd[9:5];
    w[`VCU_FUNCT3_LSB +: `VCU_FUNCT3_W] = r.funct3;
    w[`VCU_VD_LSB +: `VCU_REG_W] = rnd[14:10];
    w[`VCU_OPCODE_W-1:0] = r.opcode;
    return w;
  endfunction

  task automatic compare_row(input int idx);
    vec_row_t             r;
    logic [`VCU_ILEN-1:0] w;
    logic [1:0]           rs2_want;
    r = VECTORS[idx];
    w = sent[idx];
    check_field("ctrl_valid", ctrl_valid, r.valid);
    check_field("de_en", ctrl.de_en, r.valid & r.de_en);
    check_field("wen", ctrl.wen, r.valid ? r.wen : 2'b00);
    if (r.valid) begin
      // strided memory access takes its stride from rs2
      rs2_want = ((r.fu == FU_LOAD || r.fu == FU_STORE) && r.funct6[1:0] == 2'b10) ?
                 SRC_X : SRC_V;
      check_field("fu_type", ctrl.fu_type, r.fu);
      check_field("illegal", ctrl.illegal, r.illegal);
      check_field("rs1_type", ctrl.rs1_type, r.rs1);
      check_field("rs2_type", ctrl.rs2_type, rs2_want);
      check_field("is_signed", ctrl.is_signed, r.sgn);
      check_field("sign_extend", ctrl.sign_extend, r.sext);
      check_field("cfgsel", ctrl.cfgsel, r.cfg);
      check_field("is_load", ctrl.is_load, r.fu == FU_LOAD);
      check_field("is_store", ctrl.is_store, r.fu == FU_STORE);
      // vs1 sits in instr[19:15] and zimm[10:0] in instr[30:20]
      check_field("imm_5", ctrl.imm_5, w[19:15]);
      check_field("zimm_11", zimm_11, w[30:20]);
      case (r.fu)
        FU_MUL: check_field("mul_high/mul_signed", {ctrl.mul_high, ctrl.mul_signed}, r.sub);
        FU_DIV: check_field("div_quot/div_signed", {ctrl.div_quot, ctrl.div_signed}, r.sub);
        FU_ARITH: begin
          check_field("aluop", ctrl.aluop, r.aluop);
          if (r.aluop == VALU_COMP) begin
            check_field("comp_type", ctrl.comp_type, r.sub);
          end else if (r.aluop == VALU_MM) begin
            check_field("minmax_type", ctrl.minmax_type, r.sub);
          end else if (r.aluop == VALU_SHIFT) begin
            check_field("shift_type", ctrl.shift_type, r.sub);
          end
        end
        default: ;
      endcase
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the table did not finish in %0d ns", TIMEOUT_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    CLK = 1'b0;
    arst_n <= 1'b0;
    instr = '0;
    instr_valid = 1'b0;

    repeat (5) @(posedge CLK);
    @(negedge CLK);
    check_field("ctrl_valid", ctrl_valid, 1'b0);
    check_field("de_en", ctrl.de_en, 1'b0);
    check_field("wen", ctrl.wen, 2'b00);
    check_field("fu_type", ctrl.fu_type, FU_NONE);
    @(posedge CLK);
    arst_n <= 1'b1;

    // drive row i and check row i-1 at the next falling edge
    for (int i = 0; i <= NUM_ROWS; i++) begin
      @(posedge CLK);
      if (i < NUM_ROWS) begin
        sent[i] = build_instr(VECTORS[i]);
        instr <= sent[i];
        instr_valid <= VECTORS[i].valid;
      end else begin
        instr_valid <= 1'b0;
      end
      @(negedge CLK);
      if (i > 0) begin
        compare_row(i - 1);
      end
    end

    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, UUT.u_checker.fails);
    if (errors == 0 && UUT.u_checker.fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
+incdir+bench
src/vcu_pkg.sv
src/vop_decoder.sv
src/vfu_select.sv
src/voperand_ctrl.sv
src/vector_control_unit.sv
bench/vcu_checker.sv
bench/vcu_tb.sv

// File: Bender.yml
package:
  name: vector_control_unit

sources:
  - include_dirs:
      - src
    files:
      - src/vcu_pkg.sv
      - src/vop_decoder.sv
      - src/vfu_select.sv
      - src/voperand_ctrl.sv
      - src/vector_control_unit.sv
  - target: test
    include_dirs:
      - src
      - bench
    files:
      - bench/vcu_checker.sv
      - bench/vcu_tb.sv
